// File: hdl/wr_req_pkg.sv
package wr_req_pkg;

  typedef logic [31:0] req_word_t;
  typedef logic [4:0] fifo_count_t;   // Holds 0 to 16
  typedef logic [1:0] port_mask_t;    // One bit per input port

  localparam int IN_FIFO_DEPTH_BITS = 4;
  localparam int OUT_FIFO_DEPTH_BITS = 4;

  // Input threshold leaves room for the words still in flight from a requester
  localparam int IN_ALMOST_FULL = 8;
  localparam int OUT_ALMOST_FULL = 8;

  localparam int BURST_LEN = 4;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_DRAIN1,
    ST_DRAIN2
  } burst_state_t;

endpackage

// File: hdl/fifo_read_if.sv
`timescale 1ns/1ps

interface fifo_read_if;
  import wr_req_pkg::*;

  logic re;
  logic valid;
  req_word_t dout;
  logic burst_ready;   // At least one whole burst is stored

  modport reader (output re, input valid, input dout, input burst_ready);
  modport fifo (input re, output valid, output dout, output burst_ready);

endinterface

// File: hdl/req_fifo.sv
`timescale 1ns/1ps

module req_fifo #(
  parameter int WIDTH_BITS = 32,
  parameter int DEPTH_BITS = 4,
  parameter int ALMOST_FULL = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic we,
  input  logic [WIDTH_BITS-1:0] din,
  input  logic re,
  output logic valid,
  output logic [WIDTH_BITS-1:0] dout,
  output wr_req_pkg::fifo_count_t count,
  output logic empty,
  output logic full,
  output logic almost_full
);

  localparam int DEPTH = 2 ** DEPTH_BITS;

  logic [WIDTH_BITS-1:0] mem [DEPTH];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic do_write;
  logic do_read;

  // Writes to a full FIFO and reads from an empty one are dropped
  assign do_write = we && !full;
  assign do_read = re && !empty;

  assign empty = count == '0;
  assign full = count == $bits(count)'(DEPTH);
  assign almost_full = count >= $bits(count)'(ALMOST_FULL);

  always_ff @(posedge clk) begin
    if (do_write) mem[wr_ptr] <= din;
    if (do_read) dout <= mem[rd_ptr];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      valid <= 1'b0;
    end else begin
      valid <= do_read;   // Data shows up one cycle after the read
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
      case ({do_write, do_read})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  a_no_read_empty: assert property (@(posedge clk) disable iff (rst) re |-> !empty);
  a_no_write_full: assert property (@(posedge clk) disable iff (rst) we |-> !full);

endmodule

// File: hdl/req_ingress.sv
`timescale 1ns/1ps

module req_ingress (
  input  logic clk,
  input  logic rst,
  input  logic wr_en,
  input  wr_req_pkg::req_word_t wr_data,
  output logic available,
  fifo_read_if.fifo rd
);
  import wr_req_pkg::*;

  logic we_q;
  req_word_t din_q;
  fifo_count_t count;
  logic full;
  logic almost_full;

  always_ff @(posedge clk) begin
    if (rst) begin
      we_q <= 1'b0;
      available <= 1'b0;
    end else begin
      we_q <= wr_en;
      available <= !almost_full;   // Follows the FIFO level one cycle late
    end
  end

  always_ff @(posedge clk) din_q <= wr_data;

  req_fifo #(
    .WIDTH_BITS($bits(req_word_t)),
    .DEPTH_BITS(IN_FIFO_DEPTH_BITS),
    .ALMOST_FULL(IN_ALMOST_FULL)
  ) in_fifo (
    .clk(clk),
    .rst(rst),
    .we(we_q),
    .din(din_q),
    .re(rd.re),
    .valid(rd.valid),
    .dout(rd.dout),
    .count(count),
    .empty(),
    .full(full),
    .almost_full(almost_full)
  );

  assign rd.burst_ready = count >= fifo_count_t'(BURST_LEN);

  // A strobe from the requester must land on a FIFO with room left
  a_write_has_room: assert property (@(posedge clk) disable iff (rst) wr_en |=> !full);

endmodule

// File: hdl/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
  input  logic clk,
  input  logic rst,
  input  wr_req_pkg::port_mask_t request,
  input  logic accept,
  output wr_req_pkg::port_mask_t grant,
  output logic grant_valid
);

  logic prio;   // Port that wins a tie

  always_comb begin
    grant = '0;
    if (request[prio]) begin
      grant[prio] = 1'b1;
    end else if (request[~prio]) begin
      grant[~prio] = 1'b1;
    end
  end

  assign grant_valid = |grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      prio <= 1'b0;
    end else if (accept) begin
      // Priority moves to the port after the winner
      prio <= !grant[1];
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
    grant_valid |-> $onehot(grant));

endmodule

// File: hdl/burst_reader.sv
`timescale 1ns/1ps

module burst_reader (
  input  logic clk,
  input  logic rst,
  fifo_read_if.reader rd0,
  fifo_read_if.reader rd1,
  input  wr_req_pkg::port_mask_t grant,
  input  logic grant_valid,
  output logic accept,
  output logic fwd_valid,
  output wr_req_pkg::req_word_t fwd_data
);
  import wr_req_pkg::*;

  localparam int BEAT_BITS = $clog2(BURST_LEN);

  burst_state_t state;
  port_mask_t re_sel;
  logic [BEAT_BITS-1:0] beat;

  assign accept = (state == ST_IDLE) && grant_valid;
  assign rd0.re = re_sel[0];
  assign rd1.re = re_sel[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      re_sel <= '0;
      beat <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (grant_valid) begin
            re_sel <= grant;
            beat <= '0;
            state <= ST_READ;
          end
        end
        ST_READ: begin
          if (beat == BEAT_BITS'(BURST_LEN - 1)) begin
            re_sel <= '0;
            state <= ST_DRAIN1;
          end else begin
            beat <= beat + 1'b1;
          end
        end
        // Two idle cycles so the FIFO counts settle before the next grant
        ST_DRAIN1: state <= ST_DRAIN2;
        ST_DRAIN2: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) fwd_valid <= 1'b0;
    else fwd_valid <= rd0.valid || rd1.valid;
  end

  always_ff @(posedge clk) begin
    fwd_data <= rd0.valid ? rd0.dout : rd1.dout;   // Only one FIFO answers at a time
  end

  a_single_reader: assert property (@(posedge clk) disable iff (rst) !(rd0.re && rd1.re));

endmodule

// File: hdl/req_egress.sv
`timescale 1ns/1ps

module req_egress (
  input  logic clk,
  input  logic rst,
  input  logic fwd_valid,
  input  wr_req_pkg::req_word_t fwd_data,
  output logic almost_full,
  input  logic available_out,
  output logic en_out,
  output wr_req_pkg::req_word_t data_out
);
  import wr_req_pkg::*;

  logic re;
  logic empty;
  logic valid;
  req_word_t dout;

  // Reading stops in the same cycle the sink drops its level
  assign re = available_out && !empty;

  req_fifo #(
    .WIDTH_BITS($bits(req_word_t)),
    .DEPTH_BITS(OUT_FIFO_DEPTH_BITS),
    .ALMOST_FULL(OUT_ALMOST_FULL)
  ) out_fifo (
    .clk(clk),
    .rst(rst),
    .we(fwd_valid),
    .din(fwd_data),
    .re(re),
    .valid(valid),
    .dout(dout),
    .count(),
    .empty(empty),
    .full(),
    .almost_full(almost_full)
  );

  always_ff @(posedge clk) begin
    if (rst) en_out <= 1'b0;
    else en_out <= valid;
  end

  always_ff @(posedge clk) data_out <= dout;

endmodule

// File: hdl/wr_req_arbiter_2.sv
`timescale 1ns/1ps

module wr_req_arbiter_2 (
  input  logic clk,
  input  logic rst,
  input  wr_req_pkg::port_mask_t req_wr_en_in,
  input  wr_req_pkg::req_word_t [1:0] req_wr_data_in,
  output wr_req_pkg::port_mask_t req_wr_available_in,
  input  logic req_wr_available_out,
  output logic req_wr_en_out,
  output wr_req_pkg::req_word_t req_wr_data_out
);
  import wr_req_pkg::*;

  port_mask_t request;
  port_mask_t grant;
  logic grant_valid;
  logic accept;
  logic fwd_valid;
  req_word_t fwd_data;
  logic out_almost_full;

  fifo_read_if rd0 ();
  fifo_read_if rd1 ();

  req_ingress ingress0 (
    .clk(clk),
    .rst(rst),
    .wr_en(req_wr_en_in[0]),
    .wr_data(req_wr_data_in[0]),
    .available(req_wr_available_in[0]),
    .rd(rd0)
  );

  req_ingress ingress1 (
    .clk(clk),
    .rst(rst),
    .wr_en(req_wr_en_in[1]),
    .wr_data(req_wr_data_in[1]),
    .available(req_wr_available_in[1]),
    .rd(rd1)
  );

  // A port competes only with a whole burst and room downstream
  assign request[0] = rd0.burst_ready && !out_almost_full;
  assign request[1] = rd1.burst_ready && !out_almost_full;

  rr_arbiter arbiter (
    .clk(clk),
    .rst(rst),
    .request(request),
    .accept(accept),
    .grant(grant),
    .grant_valid(grant_valid)
  );

  burst_reader reader (
    .clk(clk),
    .rst(rst),
    .rd0(rd0),
    .rd1(rd1),
    .grant(grant),
    .grant_valid(grant_valid),
    .accept(accept),
    .fwd_valid(fwd_valid),
    .fwd_data(fwd_data)
  );

  req_egress egress (
    .clk(clk),
    .rst(rst),
    .fwd_valid(fwd_valid),
    .fwd_data(fwd_data),
    .almost_full(out_almost_full),
    .available_out(req_wr_available_out),
    .en_out(req_wr_en_out),
    .data_out(req_wr_data_out)
  );

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: sim/tb_wr_req_arbiter_2.sv
`timescale 1ns/1ps

module tb_wr_req_arbiter_2;
  import wr_req_pkg::*;

  logic clk;
  logic rst;
  port_mask_t req_wr_en_in;
  req_word_t [1:0] req_wr_data_in;
  port_mask_t req_wr_available_in;
  logic req_wr_available_out;
  logic req_wr_en_out;
  req_word_t req_wr_data_out;

  // Test file columns are port mask, bursts per port and sink stall level
  int phase_mask [$];
  int phase_bursts [$];
  int phase_stall [$];
  int total_words;
  int timeout_limit = 200;
  int cycle_count;
  bit [31:0] rng_state;
  int sent [2];        // Words handed to each port so far
  int exp_seq [2];     // Next sequence number expected at the output
  int phase_end [2];   // Sequence number at which the current phase stops
  int burst_words;
  logic burst_port;
  int last_burst_port;
  bit check_rr;
  int stall_cycles;

  tb_clock clock_gen (.clk(clk));

  wr_req_arbiter_2 wr_req_arbiter_2_inst (
    .clk(clk),
    .rst(rst),
    .req_wr_en_in(req_wr_en_in),
    .req_wr_data_in(req_wr_data_in),
    .req_wr_available_in(req_wr_available_in),
    .req_wr_available_out(req_wr_available_out),
    .req_wr_en_out(req_wr_en_out),
    .req_wr_data_out(req_wr_data_out)
  );

  function automatic bit [31:0] xorshift(input bit [31:0] state);
    bit [31:0] x;
    x = state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "Stopping at the first failure");
  endtask

  task automatic check_word(input string name, input req_word_t got, input req_word_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_mask(input string name, input port_mask_t got, input port_mask_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic read_tests();
    int fd;
    int mask;
    int bursts;
    int stall;
    fd = $fopen("sim/wr_req_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file sim/wr_req_tests.txt");
      stop_with_failure();
    end
    total_words = 0;
    while ($fscanf(fd, "%d %d %d", mask, bursts, stall) == 3) begin
      if (mask < 1 || mask > 3 || bursts < 1 || stall < 0 || stall > 3) begin
        $display("Bad test line with mask %0d, bursts %0d, stall %0d", mask, bursts, stall);
        stop_with_failure();
      end
      phase_mask.push_back(mask);
      phase_bursts.push_back(bursts);
      phase_stall.push_back(stall);
      total_words += (mask == 3 ? 2 : 1) * bursts * BURST_LEN;
    end
    $fclose(fd);
    if (phase_mask.size() == 0) begin
      $display("The test file holds no phases");
      stop_with_failure();
    end
    timeout_limit = 40 * total_words + 200;
  endtask

  // Words carry the port in bit 31 and the port's running sequence number below it
  task automatic check_output(input req_word_t word);
    int p;
    int other;
    p = word[31] ? 1 : 0;
    if (burst_words == 0) begin
      other = 1 - last_burst_port;
      // With both ports loaded and no stall the grant alternates
      if (check_rr && last_burst_port >= 0 && exp_seq[other] < phase_end[other]) begin
        check_level("req_wr_data_out[31]", word[31], last_burst_port == 0);
      end
      burst_port = word[31];
      last_burst_port = p;
    end else begin
      check_level("req_wr_data_out[31]", word[31], burst_port);   // Same port for a whole burst
    end
    if (exp_seq[p] >= sent[p]) begin
      $display("Output word %h at %0t matches no word sent on port %0d", word, $time, p);
      stop_with_failure();
    end
    check_word("req_wr_data_out", word, {word[31], 31'(exp_seq[p])});
    exp_seq[p]++;
    burst_words = (burst_words + 1) % BURST_LEN;
  endtask

  task automatic run_phase(input int mask, input int bursts, input int stall);
    bit hold;
    port_mask_t dropped;
    for (int p = 0; p < 2; p++) begin
      phase_end[p] = sent[p] + (mask[p] ? bursts * BURST_LEN : 0);
    end
    hold = (stall == 3);   // Sink stays off until every active port has backed up
    dropped = '0;
    check_rr = (mask == 3) && (stall == 0);
    last_burst_port = -1;
    while (sent[0] != phase_end[0] || sent[1] != phase_end[1] ||
           exp_seq[0] != phase_end[0] || exp_seq[1] != phase_end[1]) begin
      @(posedge clk);
      for (int p = 0; p < 2; p++) begin
        if (sent[p] < phase_end[p] && req_wr_available_in[p]) begin
          req_wr_en_in[p] <= 1'b1;
          req_wr_data_in[p] <= {p[0], 31'(sent[p])};
          sent[p]++;
        end else begin
          req_wr_en_in[p] <= 1'b0;
        end
        if (!req_wr_available_in[p]) dropped[p] = 1'b1;
      end
      if ((dropped & port_mask_t'(mask)) == port_mask_t'(mask)) hold = 1'b0;
      if (stall == 0 || stall == 3) begin
        req_wr_available_out <= !hold;
      end else begin
        rng_state = xorshift(rng_state);
        req_wr_available_out <= rng_state[1:0] >= 2'(stall);
      end
    end
  endtask

  // Outputs change on the rising edge, so they are sampled on the falling one
  always @(negedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      $display("Timeout after %0d cycles with words still outstanding", cycle_count);
      stop_with_failure();
    end
    if (rst == 1'b0) begin
      stall_cycles = req_wr_available_out ? 0 : stall_cycles + 1;
      if (stall_cycles >= 3) check_level("req_wr_en_out", req_wr_en_out, 1'b0);
      if (req_wr_en_out) check_output(req_wr_data_out);
    end
  end

  initial begin
    rst <= 1'b1;
    req_wr_en_in <= '0;
    req_wr_data_in <= '0;
    req_wr_available_out <= 1'b1;
    rng_state = 32'h27bf125d;
    cycle_count = 0;
    for (int p = 0; p < 2; p++) begin
      sent[p] = 0;
      exp_seq[p] = 0;
      phase_end[p] = 0;
    end
    burst_words = 0;
    burst_port = 1'b0;
    last_burst_port = -1;
    check_rr = 1'b0;
    stall_cycles = 0;
    read_tests();
    repeat (2) begin
      @(negedge clk);
      check_mask("req_wr_available_in", req_wr_available_in, 2'b00);
      check_level("req_wr_en_out", req_wr_en_out, 1'b0);
    end
    @(posedge clk);
    rst <= 1'b0;   // Third reset edge
    @(posedge clk);
    @(negedge clk);
    check_mask("req_wr_available_in", req_wr_available_in, 2'b11);
    for (int i = 0; i < phase_mask.size(); i++) begin
      run_phase(phase_mask[i], phase_bursts[i], phase_stall[i]);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// File: sim/wr_req_tests.txt
1 2 0
2 2 0
3 4 0
3 6 0
1 5 1
2 5 1
3 4 1
3 5 2
1 3 2
2 4 2
1 6 3
2 6 3
3 8 3
3 3 0
3 6 2
3 8 3
1 1 0
2 1 0
3 2 1
3 10 0

// File: build.f
hdl/wr_req_pkg.sv
hdl/fifo_read_if.sv
hdl/req_fifo.sv
hdl/req_ingress.sv
hdl/rr_arbiter.sv
hdl/burst_reader.sv
hdl/req_egress.sv
hdl/wr_req_arbiter_2.sv
sim/tb_clock.sv
sim/tb_wr_req_arbiter_2.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
  --top-module tb_wr_req_arbiter_2 -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_wr_req_arbiter_2 > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
